// ==== Bender.yml ====
package:
  name: loopFilter

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/loopFilterPkg.sv
      - hdl/loopRegs.sv
      - hdl/errorConditioner.sv
      - hdl/leadGain.sv
      - hdl/lagIntegrator.sv
      - hdl/loopFilter.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/loopFilterTb.sv

// ==== dv/loopFilterTb.sv ====
`timescale 1ns/1ps
`include "loopFilter_config.svh"

module loopFilterTb;

    logic        clk, reset, clkEn, cs, wr0, wr1, wr2, wr3;
    logic [11:0] addr, error;
    logic [31:0] din, dout, loopFreq;
    logic        ctrl2, ctrl4, satPos, satNeg, locked;

    // reference model state and register mirrors
    logic [11:0] mErr;
    logic [31:0] mLead, mAcc, mFreq, mCtrl, mLimit, mOffset, mLock;
    logic        mSatP, mSatN;
    logic [15:0] mRun;
    logic [15:0] lfsr = 16'd13008;
    int          errors = 0;
    int          cycles = 0;
    int          cycleLimit = 100000;   // replaced once the table is known

    // stimulus table
    string       rowName[16];
    logic [31:0] rowCtrl[16], rowLimit[16], rowOffset[16], rowLock[16];
    logic [11:0] rowFixed[16];
    int          rowCount[16], rowMode[16], rowPeriod[16], rowExpLock[16];
    int          nRows = 0;

    loopFilter i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            $display("timeout: run still going after %0d clock cycles", cycleLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    task check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task nextRandom(output logic [11:0] e);
        for (int i = 0; i < 12; i++) begin
            lfsr = lfsrStep(lfsr);
            e = {e[10:0], lfsr[0]};
        end
    endtask

    // error times 2**(x-11) with a zero exponent giving zero
    function automatic logic [31:0] scale(input logic [11:0] e, input logic [4:0] x);
        longint     v;
        logic [63:0] r;
        v = $signed(e);
        if (x == 0)
            r = 0;
        else if (x >= 11)
            r = v * (64'sd1 << (x - 11));
        else
            r = v >>> (11 - x);     // floor
        return r[31:0];
    endfunction

    function automatic logic [31:0] mkCtrl(input logic [4:0] lead, input logic [4:0] lag,
                                           input logic [4:0] flags);
        return {11'b0, lag, 3'b0, lead, 3'b0, flags};
    endfunction

    function automatic logic lockedModel();
        return (mLock[15:0] != 0) && (mRun == mLock[15:0]);
    endfunction

    // register mirror follows the byte-lane writes
    task updateMirror(input logic [11:0] a, input logic [31:0] d, input logic [3:0] lanes);
        logic [31:0] mask;
        mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        case (a)
            `LF_REG_CTRL:   mCtrl   = (mCtrl & ~mask) | (d & mask);
            `LF_REG_LIMIT:  mLimit  = (mLimit & ~mask) | (d & mask);
            `LF_REG_OFFSET: mOffset = (mOffset & ~mask) | (d & mask);
            `LF_REG_LOCK:   mLock   = (mLock & ~mask) | (d & mask);
            default: ;
        endcase
    endtask

    // one clock with the prediction made before the edge and the compare at the falling edge
    task stepCycle(input logic en, input logic [11:0] err);
        logic [11:0] nErr, mag;
        logic [31:0] nLead, nAcc, nFreq, sum, posL;
        logic        nP, nN;
        logic [15:0] nRun;
        clkEn = en;
        error = err;
        nErr = mErr;
        if (mCtrl[1])
            nErr = 0;
        else if (en)
            nErr = (mCtrl[0] ? -err : err) + mOffset[31:20];
        {nLead, nAcc, nFreq, nP, nN, nRun} = {mLead, mAcc, mFreq, mSatP, mSatN, mRun};
        if (en) begin
            nLead = scale(mErr, mCtrl[12:8]);
            sum   = mAcc + scale(mErr, mCtrl[20:16]);
            posL  = {1'b0, mLimit[30:0]};
            if ($signed(sum) >= $signed(posL))
                {nAcc, nP, nN} = {posL, 2'b10};
            else if ($signed(sum) < -$signed(posL))
                {nAcc, nP, nN} = {-posL, 2'b01};
            else
                {nAcc, nP, nN} = {sum, 2'b00};
            nFreq = mLead + mAcc;
            mag   = mErr[11] ? -mErr : mErr;
            if (mag > mLock[27:16])
                nRun = 0;
            else if (mRun < mLock[15:0])
                nRun = mRun + 1;
            else
                nRun = mLock[15:0];
        end
        if (mCtrl[3])
            {nAcc, nP, nN} = '0;
        @(posedge clk);
        {mErr, mLead, mAcc, mFreq, mSatP, mSatN, mRun} = {nErr, nLead, nAcc, nFreq, nP, nN, nRun};
        if (cs)
            updateMirror(addr, din, {wr3, wr2, wr1, wr0});   // writes land on this edge
        @(negedge clk);
        check(loopFreq, mFreq, "loopFreq");
        check(satPos, mSatP, "satPos");
        check(satNeg, mSatN, "satNeg");
        check(locked, lockedModel(), "locked");
        check({ctrl4, ctrl2}, {mCtrl[4], mCtrl[2]}, "ctrl4/ctrl2");
    endtask

    task busWrite(input logic [11:0] a, input logic [31:0] d, input logic [3:0] lanes);
        cs = 1'b1;
        addr = a;
        din = d;
        {wr3, wr2, wr1, wr0} = lanes;
        stepCycle(1'b0, 12'h0);
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0;
    endtask

    // combinational read early in the low phase and one idle clock after it
    task readCheck(input logic [11:0] a, input logic [31:0] exp, input string what);
        cs = 1'b1;
        addr = a;
        clkEn = 1'b0;
        error = 12'h0;
        #1;
        check(dout, exp, what);
        stepCycle(1'b0, 12'h0);
        cs = 1'b0;
    endtask

    task addRow(input string name, input logic [31:0] ctrl, lim, off, lock,
                input int count, mode, input logic [11:0] fixed, input int period, expLock);
        rowName[nRows]    = name;
        rowCtrl[nRows]    = ctrl;
        rowLimit[nRows]   = lim;
        rowOffset[nRows]  = off;
        rowLock[nRows]    = lock;
        rowCount[nRows]   = count;
        rowMode[nRows]    = mode;
        rowFixed[nRows]   = fixed;
        rowPeriod[nRows]  = period;
        rowExpLock[nRows] = expLock;
        nRows++;
    endtask

    initial begin
        int          errBefore, failedTests;
        logic [11:0] e;
        {reset, clkEn, cs, wr0, wr1, wr2, wr3} = 7'b1000000;
        {addr, din, error} = '0;
        {mErr, mLead, mAcc, mFreq, mSatP, mSatN, mRun} = '0;
        {mCtrl, mLimit, mOffset, mLock} = '0;
        failedTests = 0;
        // mode 0 fixed, 1 random, 2 fixed with one large error near the end
        addRow("lead exp 11", mkCtrl(11, 0, 0), 0, 0, 0, 6, 1, 0, 1, -1);
        addRow("lead exp 1", mkCtrl(1, 0, 0), 0, 0, 0, 6, 1, 0, 1, -1);
        addRow("lead exp 31", mkCtrl(31, 0, 0), 0, 0, 0, 6, 1, 0, 1, -1);
        addRow("lead exp 7", mkCtrl(7, 0, 0), 0, 0, 0, 6, 1, 0, 1, -1);
        addRow("invert", mkCtrl(11, 0, 5'b00001), 0, 0, 0, 5, 0, 12'h123, 1, -1);
        addRow("offset", mkCtrl(11, 0, 0), 0, 32'h0FF0_0000, 0, 5, 0, 12'h7F0, 1, -1);
        addRow("zero", mkCtrl(11, 0, 5'b00010), 0, 0, 0, 5, 0, 12'h555, 1, -1);
        addRow("integrate", mkCtrl(11, 16, 0), 32'd20000, 0, 0, 40, 1, 0, 1, -1);
        addRow("small limit", mkCtrl(0, 14, 0), 32'd300, 0, 0, 20, 1, 0, 1, -1);
        addRow("clear accum", mkCtrl(0, 16, 5'b01000), 32'd20000, 0, 0, 8, 1, 0, 1, -1);
        addRow("clkEn pulsed", mkCtrl(9, 12, 0), 32'd100000, 0, 0, 12, 1, 0, 3, -1);
        addRow("lock rise", mkCtrl(11, 0, 0), 0, 0, 32'h000A_0005, 12, 0, 12'h003, 1, 1);
        addRow("lock drop", mkCtrl(11, 0, 0), 0, 0, 32'h000A_0005, 10, 2, 12'h003, 1, 0);
        cycleLimit = 40;
        for (int r = 0; r < nRows; r++)
            cycleLimit += 6 + rowCount[r] * rowPeriod[r];
        cycleLimit = cycleLimit * 2 + 50;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // register access with partial byte lanes
        errBefore = errors;
        check(dout, 0, "dout with cs low");
        busWrite(`LF_REG_CTRL, 32'h5A5A_0B14, 4'b1001);
        busWrite(`LF_REG_CTRL, 32'hFFFF_0BFF, 4'b0010);
        busWrite(`LF_REG_LIMIT, 32'h1234_5678, 4'b0101);
        busWrite(`LF_REG_LIMIT, 32'hAABB_CCDD, 4'b1010);
        busWrite(`LF_REG_OFFSET, 32'h8765_4321, 4'b1111);
        busWrite(`LF_REG_LOCK, 32'h00C0_0004, 4'b1100);
        busWrite(`LF_REG_ACCUM, 32'hFFFF_FFFF, 4'b1111);    // read only so ignored
        busWrite(`LF_REG_STATUS, 32'hFFFF_FFFF, 4'b1111);
        readCheck(`LF_REG_CTRL, mCtrl, "ctrl readback");
        readCheck(`LF_REG_LIMIT, mLimit, "limit readback");
        readCheck(`LF_REG_OFFSET, mOffset, "offset readback");
        readCheck(`LF_REG_LOCK, mLock, "lock readback");
        readCheck(`LF_REG_ACCUM, mAcc, "accum readback");
        readCheck(`LF_REG_STATUS, {29'b0, mSatN, mSatP, lockedModel()}, "status readback");
        if (errors != errBefore)
            failedTests++;
        $display("test 0 %-14s %s", "registers", (errors == errBefore) ? "passed" : "FAILED");

        for (int r = 0; r < nRows; r++) begin
            errBefore = errors;
            busWrite(`LF_REG_CTRL, rowCtrl[r], 4'hF);
            busWrite(`LF_REG_LIMIT, rowLimit[r], 4'hF);
            busWrite(`LF_REG_OFFSET, rowOffset[r], 4'hF);
            busWrite(`LF_REG_LOCK, rowLock[r], 4'hF);
            for (int k = 0; k < rowCount[r]; k++) begin
                if (rowMode[r] == 1)
                    nextRandom(e);
                else if (rowMode[r] == 2 && k == rowCount[r] - 4)
                    e = 12'h400;
                else
                    e = rowFixed[r];
                for (int p = 0; p < rowPeriod[r]; p++)
                    stepCycle(p == rowPeriod[r] - 1, e);   // one clkEn per period
            end
            readCheck(`LF_REG_ACCUM, mAcc, "accum readback");
            readCheck(`LF_REG_STATUS, {29'b0, mSatN, mSatP, lockedModel()}, "status readback");
            if (rowExpLock[r] >= 0)
                check(locked, rowExpLock[r], "final lock state");
            if (errors != errBefore)
                failedTests++;
            $display("test %0d %-14s %s", r + 1, rowName[r],
                     (errors == errBefore) ? "passed" : "FAILED");
        end

        $display("%0d tests run, %0d failed, %0d mismatches", nRows + 1, failedTests, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== hdl/errorConditioner.sv ====
`timescale 1ns/1ps
`include "loopFilter_config.svh"

module errorConditioner import loopFilterPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clkEn,
    input  logic [`LF_ERR_W-1:0]   error,
    input  logic                   invertError,
    input  logic                   zeroError,
    input  logic [`LF_ERR_W-1:0]   loopOffset,
    input  logic [`LF_LOCK_W-1:0]  lockCount,
    input  logic [`LF_ERR_W-1:0]   syncThreshold,
    output logic [`LF_ERR_W-1:0]   loopError,
    output logic                   locked
);

    logic [`LF_ERR_W-1:0]   signedErr;
    logic [`LF_ERR_W-1:0]   errMag;
    logic [`LF_LOCK_W-1:0]  runCount;
    logic                   inWindow;

    assign signedErr = invertError ? -error : error;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loopError <= '0;
        end else if (zeroError) begin      // holds at zero even without clkEn
            loopError <= '0;
        end else if (clkEn) begin
            loopError <= signedErr + loopOffset;   // wraps at 12 bits
        end
    end

    // magnitude as unsigned, so -2048 maps to 2048
    assign errMag   = loopError[`LF_ERR_W-1] ? -loopError : loopError;
    assign inWindow = (errMag <= syncThreshold);

    // run of consecutive small errors
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            runCount <= '0;
        end else if (clkEn) begin
            if (!inWindow)
                runCount <= '0;
            else if (runCount < lockCount)
                runCount <= runCount + 1'b1;
            else
                runCount <= lockCount;         // saturate even after lockCount drops
        end
    end

    assign locked = (lockCount != '0) && (runCount == lockCount);

endmodule

// ==== hdl/lagIntegrator.sv ====
`timescale 1ns/1ps
`include "loopFilter_config.svh"

module lagIntegrator import loopFilterPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clkEn,
    input  logic [`LF_ERR_W-1:0]   loopError,
    input  logic [`LF_EXP_W-1:0]   lagExp,
    input  logic [`LF_DATA_W-1:0]  limit,
    input  logic                   clearAccum,
    output logic [`LF_DATA_W-1:0]  lagAccum,
    output logic                   satPos,
    output logic                   satNeg
);

    logic        [`LF_DATA_W-1:0] lagError;
    logic signed [`LF_DATA_W-1:0] sum;
    logic signed [`LF_DATA_W-1:0] posLimit;
    logic signed [`LF_DATA_W-1:0] negLimit;

    // unregistered, keeps lagAccum in step with leadError
    assign lagError = gainShift(loopError, lagExp);
    assign sum      = signed'(lagAccum + lagError);

    // top bit dropped so the limit is never negative
    assign posLimit = signed'({1'b0, limit[`LF_DATA_W-2:0]});
    assign negLimit = -posLimit;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagAccum <= '0;
            satPos   <= 1'b0;
            satNeg   <= 1'b0;
        end else if (clearAccum) begin     // level, not gated by clkEn
            lagAccum <= '0;
            satPos   <= 1'b0;
            satNeg   <= 1'b0;
        end else if (clkEn) begin
            if (sum >= posLimit) begin
                lagAccum <= posLimit;
                satPos   <= 1'b1;
                satNeg   <= 1'b0;
            end else if (sum < negLimit) begin
                lagAccum <= negLimit;
                satPos   <= 1'b0;
                satNeg   <= 1'b1;
            end else begin
                lagAccum <= sum;
                satPos   <= 1'b0;
                satNeg   <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/leadGain.sv ====
`timescale 1ns/1ps
`include "loopFilter_config.svh"

module leadGain import loopFilterPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clkEn,
    input  logic [`LF_ERR_W-1:0]   loopError,
    input  logic [`LF_EXP_W-1:0]   leadExp,
    output logic [`LF_DATA_W-1:0]  leadError
);

    logic [`LF_DATA_W-1:0] scaled;

    // proportional term
    assign scaled = gainShift(loopError, leadExp);

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            leadError <= '0;
        else if (clkEn)
            leadError <= scaled;
    end

endmodule

// ==== hdl/loopFilter.sv ====
`timescale 1ns/1ps
`include "loopFilter_config.svh"

module loopFilter import loopFilterPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clkEn,
    input  logic                   cs,
    input  logic                   wr0,
    input  logic                   wr1,
    input  logic                   wr2,
    input  logic                   wr3,
    input  logic [`LF_ADDR_W-1:0]  addr,
    input  logic [`LF_DATA_W-1:0]  din,
    output logic [`LF_DATA_W-1:0]  dout,
    input  logic [`LF_ERR_W-1:0]   error,
    output logic [`LF_DATA_W-1:0]  loopFreq,
    output logic                   ctrl2,
    output logic                   ctrl4,
    output logic                   satPos,
    output logic                   satNeg,
    output logic                   locked
);

    logic                  invertError, zeroError, clearAccum;
    logic [`LF_EXP_W-1:0]  leadExp, lagExp;
    logic [`LF_DATA_W-1:0] limit;
    logic [`LF_ERR_W-1:0]  loopOffset, syncThreshold, loopError;
    logic [`LF_LOCK_W-1:0] lockCount;
    logic [`LF_DATA_W-1:0] leadError, lagAccum, filterSum;

    loopRegs i_regs (
        .clk, .reset, .cs, .wr0, .wr1, .wr2, .wr3, .addr, .din, .dout,
        .lagAccum, .satPos, .satNeg, .locked,
        .invertError, .zeroError, .ctrl2, .clearAccum, .ctrl4,
        .leadExp, .lagExp, .limit, .loopOffset, .lockCount, .syncThreshold
    );

    errorConditioner i_cond (
        .clk, .reset, .clkEn, .error, .invertError, .zeroError,
        .loopOffset, .lockCount, .syncThreshold, .loopError, .locked
    );

    leadGain i_lead (
        .clk, .reset, .clkEn, .loopError, .leadExp, .leadError
    );

    lagIntegrator i_lag (
        .clk, .reset, .clkEn, .loopError, .lagExp, .limit, .clearAccum,
        .lagAccum, .satPos, .satNeg
    );

    assign filterSum = leadError + lagAccum;   // lead plus lag wraps at 32 bits

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            loopFreq <= '0;
        else if (clkEn)
            loopFreq <= filterSum;
    end

endmodule

// ==== hdl/loopFilterPkg.sv ====
`include "loopFilter_config.svh"

package loopFilterPkg;

    // control word, bit 0 first from the bottom of the struct
    typedef struct packed {
        logic [10:0]           spare21;
        logic [`LF_EXP_W-1:0]  lagExp;
        logic [2:0]            spare13;
        logic [`LF_EXP_W-1:0]  leadExp;
        logic [2:0]            spare5;
        logic                  ctrl4;
        logic                  clearAccum;
        logic                  ctrl2;
        logic                  zeroError;
        logic                  invertError;
    } ctrlFields_t;

    typedef union packed {
        logic [`LF_DATA_W-1:0] raw;     // bus view
        ctrlFields_t           fields;  // decoded view
    } ctrlReg_t;

    // error times 2**(exponent-11), exponent 0 turns the path off
    function automatic logic [`LF_DATA_W-1:0] gainShift(
        input logic [`LF_ERR_W-1:0] err,
        input logic [`LF_EXP_W-1:0] exponent
    );
        logic signed [`LF_DATA_W-1:0] wide;
        wide = signed'({{(`LF_DATA_W-`LF_ERR_W){err[`LF_ERR_W-1]}}, err});
        if (exponent == '0)
            return '0;
        else if (exponent < `LF_UNITY_EXP)
            return wide >>> (`LF_UNITY_EXP - exponent);  // floors toward -inf
        else
            return wide << (exponent - `LF_UNITY_EXP);
    endfunction

endpackage

// ==== hdl/loopFilter_config.svh ====
`ifndef LOOPFILTER_CONFIG_SVH
`define LOOPFILTER_CONFIG_SVH

// datapath widths
`define LF_ERR_W        12
`define LF_DATA_W       32
`define LF_ADDR_W       12
`define LF_EXP_W        5
`define LF_UNITY_EXP    11      // exponent giving a gain of one
`define LF_LOCK_W       16

// register map, byte addresses
`define LF_REG_CTRL     12'h000
`define LF_REG_LIMIT    12'h004
`define LF_REG_OFFSET   12'h008
`define LF_REG_LOCK     12'h00C
`define LF_REG_ACCUM    12'h010 // read only
`define LF_REG_STATUS   12'h014 // read only

// field positions
`define LF_OFFSET_LSB   20      // offset lives in the top 12 bits
`define LF_SYNC_LSB     16      // syncThreshold within the lock word
`define LF_STAT_LOCKED  0
`define LF_STAT_SATPOS  1
`define LF_STAT_SATNEG  2

`endif

// ==== hdl/loopRegs.sv ====
`timescale 1ns/1ps
`include "loopFilter_config.svh"

module loopRegs import loopFilterPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cs,
    input  logic                   wr0,
    input  logic                   wr1,
    input  logic                   wr2,
    input  logic                   wr3,
    input  logic [`LF_ADDR_W-1:0]  addr,
    input  logic [`LF_DATA_W-1:0]  din,
    output logic [`LF_DATA_W-1:0]  dout,
    input  logic [`LF_DATA_W-1:0]  lagAccum,
    input  logic                   satPos,
    input  logic                   satNeg,
    input  logic                   locked,
    output logic                   invertError,
    output logic                   zeroError,
    output logic                   ctrl2,
    output logic                   clearAccum,
    output logic                   ctrl4,
    output logic [`LF_EXP_W-1:0]   leadExp,
    output logic [`LF_EXP_W-1:0]   lagExp,
    output logic [`LF_DATA_W-1:0]  limit,
    output logic [`LF_ERR_W-1:0]   loopOffset,
    output logic [`LF_LOCK_W-1:0]  lockCount,
    output logic [`LF_ERR_W-1:0]   syncThreshold
);

    ctrlReg_t               ctrlReg;
    logic [`LF_DATA_W-1:0]  limitReg;
    logic [`LF_DATA_W-1:0]  offsetReg;
    logic [`LF_DATA_W-1:0]  lockReg;
    logic [`LF_DATA_W-1:0]  statusWord;
    logic [3:0]             lanes;

    // merge the strobed byte lanes into the old value
    function automatic logic [`LF_DATA_W-1:0] laneWrite(
        input logic [`LF_DATA_W-1:0] cur,
        input logic [`LF_DATA_W-1:0] data,
        input logic [3:0]            wrEn
    );
        logic [`LF_DATA_W-1:0] res;
        res = cur;
        for (int b = 0; b < 4; b++) begin
            if (wrEn[b])
                res[b*8 +: 8] = data[b*8 +: 8];
        end
        return res;
    endfunction

    assign lanes = {wr3, wr2, wr1, wr0};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrlReg.raw <= '0;
            limitReg    <= '0;
            offsetReg   <= '0;
            lockReg     <= '0;
        end else if (cs) begin   // no strobe leaves the word unchanged
            case (addr)
                `LF_REG_CTRL:   ctrlReg.raw <= laneWrite(ctrlReg.raw, din, lanes);
                `LF_REG_LIMIT:  limitReg    <= laneWrite(limitReg, din, lanes);
                `LF_REG_OFFSET: offsetReg   <= laneWrite(offsetReg, din, lanes);
                `LF_REG_LOCK:   lockReg     <= laneWrite(lockReg, din, lanes);
                default: ;                   // accum and status are read only
            endcase
        end
    end

    always_comb begin
        statusWord = '0;
        statusWord[`LF_STAT_LOCKED] = locked;
        statusWord[`LF_STAT_SATPOS] = satPos;
        statusWord[`LF_STAT_SATNEG] = satNeg;
    end

    // readback, zero when not selected
    always_comb begin
        dout = '0;
        if (cs) begin
            case (addr)
                `LF_REG_CTRL:   dout = ctrlReg.raw;
                `LF_REG_LIMIT:  dout = limitReg;
                `LF_REG_OFFSET: dout = offsetReg;
                `LF_REG_LOCK:   dout = lockReg;
                `LF_REG_ACCUM:  dout = lagAccum;
                `LF_REG_STATUS: dout = statusWord;
                default:        dout = '0;
            endcase
        end
    end

    assign invertError   = ctrlReg.fields.invertError;
    assign zeroError     = ctrlReg.fields.zeroError;
    assign ctrl2         = ctrlReg.fields.ctrl2;
    assign clearAccum    = ctrlReg.fields.clearAccum;
    assign ctrl4         = ctrlReg.fields.ctrl4;
    assign leadExp       = ctrlReg.fields.leadExp;
    assign lagExp        = ctrlReg.fields.lagExp;
    assign limit         = limitReg;
    assign loopOffset    = offsetReg[`LF_OFFSET_LSB +: `LF_ERR_W];
    assign lockCount     = lockReg[`LF_LOCK_W-1:0];
    assign syncThreshold = lockReg[`LF_SYNC_LSB +: `LF_ERR_W];

endmodule

// ==== loopFilter.f ====
+incdir+hdl
hdl/loopFilterPkg.sv
hdl/loopRegs.sv
hdl/errorConditioner.sv
hdl/leadGain.sv
hdl/lagIntegrator.sv
hdl/loopFilter.sv
dv/loopFilterTb.sv
